// ==== osdPkg.sv ====
/* OSD sizes, tint colour, pipeline delay,
   command opcode and control state enums */
package osdPkg;

    // bitmap window, one OSD pixel per video pixel
    localparam int OSD_WIDTH  = 256;
    localparam int OSD_HEIGHT = 64;
    localparam int OSD_BYTES  = 2048;
    localparam int ADDR_BITS  = 11;

    localparam int PIX_BITS   = 24;
    localparam int COUNT_BITS = 12;

    // two bits each for red, green, blue
    localparam logic [5:0] OSD_TINT = 6'h3c;

    // source input to mixed output
    localparam int PIPE_DELAY = 4;

    // decoded from the upper bits of the command byte
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_WRITE,
        CMD_ENABLE
    } osdCmdE;

    typedef enum logic [1:0] {
        IDLE,
        CMD,
        DATA
    } ctrlStateE;

endpackage

// ==== osdFetchIf.sv ====
/* Pixel fetch path from window geometry
   through the bitmap buffer to the mixer */
interface osdFetchIf;
    import osdPkg::*;

    logic [ADDR_BITS-1:0] fetchAddr;
    logic [2:0]           bitSel;
    logic                 inWindow;

    // one cycle behind the request
    logic                 osdBit;
    logic                 osdActive;

    modport geometry (
        output fetchAddr,
        output bitSel,
        output inWindow
    );

    modport buffer (
        input  fetchAddr,
        input  bitSel,
        input  inWindow,
        output osdBit,
        output osdActive
    );

    modport mixer (
        input osdBit,
        input osdActive
    );

endinterface

// ==== osdControl.sv ====
/* Host strobe port decoder with bitmap
   write addressing, overlay enable and status */
module osdControl (
    input  logic                         clk_video,
    input  logic                         reset,
    input  logic                         ioSelect,
    input  logic                         ioStrobe,
    input  logic [15:0]                  ioData,
    output logic                         bufWrite,
    output logic [osdPkg::ADDR_BITS-1:0] bufAddr,
    output logic [7:0]                   bufData,
    output logic                         osdEnable,
    output logic                         osdStatus
);
    import osdPkg::*;

    ctrlStateE            state;
    osdCmdE               cmdKind;
    osdCmdE               cmdNow;
    logic                 selQ;
    logic                 selD;
    logic                 strobeQ;
    logic                 strobeD;
    logic                 strobeRise;
    logic [7:0]           dataQ;
    logic [7:0]           wordQ;
    logic [ADDR_BITS-1:0] wrAddr;
    logic                 pendingEnable;

    function automatic osdCmdE decodeCmd(input logic [7:0] cmdByte);
        if (cmdByte[7:5] == 3'b001) begin
            return CMD_WRITE;
        end
        if (cmdByte[7:4] == 4'b0100) begin
            return CMD_ENABLE;
        end
        return CMD_NONE;
    endfunction

    assign cmdNow = decodeCmd(wordQ);

    // sample the port, then register the strobe edge with its word
    always_ff @(posedge clk_video) begin
        dataQ <= ioData[7:0];
        wordQ <= dataQ;
        if (reset) begin
            selQ       <= 1'b0;
            selD       <= 1'b0;
            strobeQ    <= 1'b0;
            strobeD    <= 1'b0;
            strobeRise <= 1'b0;
        end else begin
            selQ       <= ioSelect;
            selD       <= selQ;
            strobeQ    <= ioStrobe;
            strobeD    <= strobeQ;
            strobeRise <= strobeQ & ~strobeD;
        end
    end

    always_ff @(posedge clk_video) begin
        if (reset) begin
            state         <= IDLE;
            cmdKind       <= CMD_NONE;
            pendingEnable <= 1'b0;
            osdEnable     <= 1'b0;
            osdStatus     <= 1'b0;
            bufWrite      <= 1'b0;
        end else begin
            bufWrite <= 1'b0;
            if (!selD) begin
                // enable commits as the transaction closes
                if (state != IDLE && cmdKind == CMD_ENABLE) begin
                    osdEnable <= pendingEnable;
                end
                state   <= IDLE;
                cmdKind <= CMD_NONE;
            end else begin
                case (state)
                    IDLE, CMD: begin
                        state <= CMD;
                        if (strobeRise) begin
                            cmdKind <= cmdNow;
                            if (cmdNow == CMD_ENABLE) begin
                                pendingEnable <= wordQ[0];
                                osdStatus     <= wordQ[0];
                            end
                            state <= DATA;
                        end
                    end
                    DATA: begin
                        if (strobeRise && cmdKind == CMD_WRITE) begin
                            bufWrite <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // write address, start page from the command byte
    always_ff @(posedge clk_video) begin
        if (selD && strobeRise) begin
            if (state == DATA) begin
                bufAddr <= wrAddr;
                bufData <= wordQ;
                wrAddr  <= wrAddr + 1'b1;
            end else if (cmdNow == CMD_WRITE) begin
                wrAddr <= {wordQ[2:0], 8'h00};
            end
        end
    end

endmodule

// ==== osdBuffer.sv ====
/* Bitmap RAM for the OSD window with host
   write port and registered pixel bit fetch */
module osdBuffer (
    input  logic                         clk_video,
    input  logic                         bufWrite,
    input  logic [osdPkg::ADDR_BITS-1:0] bufAddr,
    input  logic [7:0]                   bufData,
    osdFetchIf.buffer                    fetch
);
    import osdPkg::*;

    // eight vertical pixels per byte
    logic [7:0] bitmap [OSD_BYTES];
    logic [7:0] rdByte;

    always_ff @(posedge clk_video) begin
        if (bufWrite) begin
            bitmap[bufAddr] <= bufData;
        end
    end

    assign rdByte = bitmap[fetch.fetchAddr];

    // bit and window flag stay aligned
    always_ff @(posedge clk_video) begin
        fetch.osdBit    <= rdByte[fetch.bitSel];
        fetch.osdActive <= fetch.inWindow;
    end

endmodule

// ==== osdGeometry.sv ====
/* Line and frame measurement, centred window
   placement and bitmap address generation */
module osdGeometry (
    input  logic        clk_video,
    input  logic        reset,
    input  logic        de,
    input  logic        vs,
    input  logic        osdEnable,
    osdFetchIf.geometry fetch
);
    import osdPkg::*;

    logic                  deD;
    logic                  vsD;
    logic                  deRise;
    logic                  deFall;
    logic                  vsRise;
    logic [COUNT_BITS-1:0] pixCnt;
    logic [COUNT_BITS-1:0] lineCnt;
    logic [COUNT_BITS-1:0] lineWidth;
    logic [COUNT_BITS-1:0] frameHeight;
    logic [COUNT_BITS-1:0] hStart;
    logic [COUNT_BITS-1:0] vStart;
    logic [COUNT_BITS-1:0] rowOff;
    logic [COUNT_BITS-1:0] colOff;
    logic                  frameSeen;
    logic                  winOn;
    logic                  rowIn;
    logic                  lineHit;
    logic                  rowHit;
    logic                  colHit;
    logic [5:0]            rowNum;
    logic [5:0]            rowNow;

    assign deRise = de & ~deD;
    assign deFall = ~de & deD;
    assign vsRise = vs & ~vsD;

    assign vStart = (frameHeight - COUNT_BITS'(OSD_HEIGHT)) >> 1;

    // lineCnt still holds the index of this line at its de rise
    assign rowOff  = lineCnt - vStart;
    assign lineHit = (lineCnt >= vStart) && (lineCnt < vStart + COUNT_BITS'(OSD_HEIGHT));
    assign rowHit  = deRise ? lineHit : rowIn;
    assign rowNow  = deRise ? rowOff[5:0] : rowNum;

    assign colOff = pixCnt - hStart;
    assign colHit = (pixCnt >= hStart) && (pixCnt < hStart + COUNT_BITS'(OSD_WIDTH));

    always_ff @(posedge clk_video) begin
        if (reset) begin
            deD            <= 1'b0;
            vsD            <= 1'b0;
            pixCnt         <= '0;
            lineCnt        <= '0;
            lineWidth      <= '0;
            frameHeight    <= '0;
            hStart         <= '0;
            frameSeen      <= 1'b0;
            winOn          <= 1'b0;
            rowIn          <= 1'b0;
            fetch.inWindow <= 1'b0;
        end else begin
            deD    <= de;
            vsD    <= vs;
            pixCnt <= de ? pixCnt + 1'b1 : '0;
            if (deFall) begin
                lineWidth <= pixCnt;
            end
            if (vsRise) begin
                // frame start, load H and sample the enable
                lineCnt     <= '0;
                frameHeight <= lineCnt;
                hStart      <= (lineWidth - COUNT_BITS'(OSD_WIDTH)) >> 1;
                frameSeen   <= 1'b1;
                winOn       <= osdEnable && frameSeen &&
                               (lineCnt >= COUNT_BITS'(OSD_HEIGHT)) &&
                               (lineWidth >= COUNT_BITS'(OSD_WIDTH));
            end else if (deRise) begin
                lineCnt <= lineCnt + 1'b1;
                rowIn   <= lineHit;
            end
            fetch.inWindow <= de && winOn && rowHit && colHit;
        end
    end

    // row in upper address bits, bit index within the byte
    always_ff @(posedge clk_video) begin
        if (deRise) begin
            rowNum <= rowOff[5:0];
        end
        fetch.fetchAddr <= {rowNow[5:3], colOff[7:0]};
        fetch.bitSel    <= rowNow[2:0];
    end

endmodule

// ==== osdMixer.sv ====
/* Tinted colour blend of the OSD bit with the source,
   aligned delay of pixel data and syncs */
module osdMixer (
    input  logic                        clk_video,
    input  logic                        reset,
    input  logic [osdPkg::PIX_BITS-1:0] rgb,
    input  logic                        de,
    input  logic                        hs,
    input  logic                        vs,
    osdFetchIf.mixer                    fetch,
    output logic [osdPkg::PIX_BITS-1:0] mixedRgb,
    output logic                        mixedDe,
    output logic                        mixedHs,
    output logic                        mixedVs
);
    import osdPkg::*;

    // source waits here for the fetched bit
    logic [PIX_BITS-1:0]   rgbPipe [PIPE_DELAY-2];
    logic [PIX_BITS-1:0]   srcAligned;
    logic [PIX_BITS-1:0]   tinted;
    logic [PIX_BITS-1:0]   mixStage;
    logic [PIPE_DELAY-1:0] dePipe;
    logic [PIPE_DELAY-1:0] hsPipe;
    logic [PIPE_DELAY-1:0] vsPipe;

    assign srcAligned = rgbPipe[PIPE_DELAY-3];

    // bit, tint, then dimmed source per channel
    assign tinted = {fetch.osdBit, OSD_TINT[5:4], srcAligned[23:19],
                     fetch.osdBit, OSD_TINT[3:2], srcAligned[15:11],
                     fetch.osdBit, OSD_TINT[1:0], srcAligned[7:3]};

    always_ff @(posedge clk_video) begin
        rgbPipe[0] <= rgb;
        for (int i = 1; i < PIPE_DELAY - 2; i++) begin
            rgbPipe[i] <= rgbPipe[i-1];
        end
        mixStage <= fetch.osdActive ? tinted : srcAligned;
        mixedRgb <= mixStage;
    end

    always_ff @(posedge clk_video) begin
        if (reset) begin
            dePipe <= '0;
            hsPipe <= '0;
            vsPipe <= '0;
        end else begin
            dePipe <= {dePipe[PIPE_DELAY-2:0], de};
            hsPipe <= {hsPipe[PIPE_DELAY-2:0], hs};
            vsPipe <= {vsPipe[PIPE_DELAY-2:0], vs};
        end
    end

    assign mixedDe = dePipe[PIPE_DELAY-1];
    assign mixedHs = hsPipe[PIPE_DELAY-1];
    assign mixedVs = vsPipe[PIPE_DELAY-1];

endmodule

// ==== osdOverlay.sv ====
/* OSD overlay top level between video source and output,
   host command port, geometry, buffer and mixer */
module osdOverlay (
    input  logic                        clk_video,
    input  logic                        reset,
    input  logic                        ioSelect,
    input  logic                        ioStrobe,
    input  logic [15:0]                 ioData,
    input  logic [osdPkg::PIX_BITS-1:0] rgb,
    input  logic                        de,
    input  logic                        hs,
    input  logic                        vs,
    output logic [osdPkg::PIX_BITS-1:0] mixedRgb,
    output logic                        mixedDe,
    output logic                        mixedHs,
    output logic                        mixedVs,
    output logic                        osdStatus
);
    import osdPkg::*;

    logic                 bufWrite;
    logic [ADDR_BITS-1:0] bufAddr;
    logic [7:0]           bufData;
    logic                 osdEnable;

    osdFetchIf fetchBus ();

    osdControl u_control (
        .clk_video (clk_video),
        .reset     (reset),
        .ioSelect  (ioSelect),
        .ioStrobe  (ioStrobe),
        .ioData    (ioData),
        .bufWrite  (bufWrite),
        .bufAddr   (bufAddr),
        .bufData   (bufData),
        .osdEnable (osdEnable),
        .osdStatus (osdStatus)
    );

    osdGeometry u_geometry (
        .clk_video (clk_video),
        .reset     (reset),
        .de        (de),
        .vs        (vs),
        .osdEnable (osdEnable),
        .fetch     (fetchBus.geometry)
    );

    osdBuffer u_buffer (
        .clk_video (clk_video),
        .bufWrite  (bufWrite),
        .bufAddr   (bufAddr),
        .bufData   (bufData),
        .fetch     (fetchBus.buffer)
    );

    osdMixer u_mixer (
        .clk_video (clk_video),
        .reset     (reset),
        .rgb       (rgb),
        .de        (de),
        .hs        (hs),
        .vs        (vs),
        .fetch     (fetchBus.mixer),
        .mixedRgb  (mixedRgb),
        .mixedDe   (mixedDe),
        .mixedHs   (mixedHs),
        .mixedVs   (mixedVs)
    );

endmodule

// ==== osdOverlay_properties.sv ====
/* Concurrent checks on output pipeline timing,
   status stability and quiet outputs after reset */
module osdOverlayProperties (
    input logic clk_video,
    input logic reset,
    input logic ioSelect,
    input logic de,
    input logic hs,
    input logic vs,
    input logic mixedDe,
    input logic mixedHs,
    input logic mixedVs,
    input logic osdStatus
);
    timeunit 1ns;
    timeprecision 100ps;
    import osdPkg::*;

    // cycles since reset, saturates at the pipeline depth
    logic [2:0] runCycles;

    always_ff @(posedge clk_video) begin
        if (reset) begin
            runCycles <= '0;
        end else if (runCycles < 3'(PIPE_DELAY)) begin
            runCycles <= runCycles + 1'b1;
        end
    end

    deDelay: assert property (@(posedge clk_video) disable iff (reset)
        runCycles == 3'(PIPE_DELAY) |-> mixedDe == $past(de, PIPE_DELAY))
        else $error("mixedDe is not de delayed by the pipeline depth");

    hsDelay: assert property (@(posedge clk_video) disable iff (reset)
        runCycles == 3'(PIPE_DELAY) |-> mixedHs == $past(hs, PIPE_DELAY))
        else $error("mixedHs is not hs delayed by the pipeline depth");

    vsDelay: assert property (@(posedge clk_video) disable iff (reset)
        runCycles == 3'(PIPE_DELAY) |-> mixedVs == $past(vs, PIPE_DELAY))
        else $error("mixedVs is not vs delayed by the pipeline depth");

    statusHold: assert property (@(posedge clk_video) disable iff (reset)
        !ioSelect && !$past(ioSelect) && !$past(ioSelect, 2) |-> $stable(osdStatus))
        else $error("osdStatus changed while the host port was deselected");

    quietStart: assert property (@(posedge clk_video) disable iff (reset)
        runCycles < 3'(PIPE_DELAY) |-> !mixedDe)
        else $error("mixedDe high in the first cycles after reset");

endmodule

bind osdOverlay osdOverlayProperties u_properties (
    .clk_video (clk_video),
    .reset     (reset),
    .ioSelect  (ioSelect),
    .de        (de),
    .hs        (hs),
    .vs        (vs),
    .mixedDe   (mixedDe),
    .mixedHs   (mixedHs),
    .mixedVs   (mixedVs),
    .osdStatus (osdStatus)
);

// ==== tbOsdOverlay.sv ====
/* Testbench for the OSD overlay with clock, reset, video raster,
   host command table, reference model, checks and watchdog */
module tbOsdOverlay;
    timeunit 1ns;
    timeprecision 100ps;
    import osdPkg::*;

    localparam int SEED         = 60990;
    localparam int ACTIVE_W     = 320;
    localparam int ACTIVE_H     = 100;
    localparam int LINE_CYCLES  = 344;
    localparam int VBLANK       = 4;
    localparam int FRAME_CYCLES = LINE_CYCLES * (ACTIVE_H + VBLANK);
    localparam int H_START      = (ACTIVE_W - OSD_WIDTH) / 2;
    localparam int V_START      = (ACTIVE_H - OSD_HEIGHT) / 2;
    localparam int NUM_TESTS    = 5;
    localparam int MAX_SHOWN    = 20;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WRITE,
        OP_ENABLE
    } hostOpE;

    // enable is also the osdStatus expected after the row
    typedef struct packed {
        hostOpE      op;
        logic [2:0]  page;
        logic [11:0] count;
        logic        enable;
        logic [3:0]  frames;
    } testRowT;

    typedef struct packed {
        logic [PIX_BITS-1:0] rgb;
        logic                rgbValid;
        logic                de;
        logic                hs;
        logic                vs;
    } expectT;

    localparam testRowT TEST_TABLE [NUM_TESTS] = '{
        '{OP_IDLE,   3'd0, 12'd0,    1'b0, 4'd2},
        '{OP_WRITE,  3'd0, 12'd2048, 1'b0, 4'd1},
        '{OP_ENABLE, 3'd0, 12'd0,    1'b1, 4'd2},
        '{OP_WRITE,  3'd5, 12'd768,  1'b1, 4'd2},
        '{OP_ENABLE, 3'd0, 12'd0,    1'b0, 4'd2}
    };

    logic                clk_video;
    logic                reset;
    logic                ioSelect;
    logic                ioStrobe;
    logic [15:0]         ioData;
    logic [PIX_BITS-1:0] rgb;
    logic                de;
    logic                hs;
    logic                vs;
    logic [PIX_BITS-1:0] mixedRgb;
    logic                mixedDe;
    logic                mixedHs;
    logic                mixedVs;
    logic                osdStatus;

    // reference copy of the bitmap and overlay state
    logic [7:0] bitmapModel [OSD_BYTES];
    logic       modelEnable;
    logic       frameWin;
    logic       frameDirty;
    logic       hostBusy;
    int         vsCount;
    int         errorCount;
    int         checkCount;
    expectT     expectQ [$];
    event       frameStart;

    osdOverlay u_dut (
        .clk_video (clk_video),
        .reset     (reset),
        .ioSelect  (ioSelect),
        .ioStrobe  (ioStrobe),
        .ioData    (ioData),
        .rgb       (rgb),
        .de        (de),
        .hs        (hs),
        .vs        (vs),
        .mixedRgb  (mixedRgb),
        .mixedDe   (mixedDe),
        .mixedHs   (mixedHs),
        .mixedVs   (mixedVs),
        .osdStatus (osdStatus)
    );

    initial begin
        clk_video = 1'b0;
        forever #5 clk_video = ~clk_video;
    end

    function automatic int tableFrames();
        int total;
        total = 0;
        foreach (TEST_TABLE[i]) begin
            total += int'(TEST_TABLE[i].frames) + 1;
        end
        return total;
    endfunction

    // window pixel made of bitmap bit, tint pair and upper five source bits
    function automatic logic [PIX_BITS-1:0] blendPixel(input logic [PIX_BITS-1:0] src,
                                                       input int r, input int x);
        logic [ADDR_BITS-1:0] addr;
        logic                 b;
        addr = ADDR_BITS'((r / 8) * OSD_WIDTH + x);
        b    = bitmapModel[addr][3'(r % 8)];
        return {b, OSD_TINT[5:4], src[23:19],
                b, OSD_TINT[3:2], src[15:11],
                b, OSD_TINT[1:0], src[7:3]};
    endfunction

    task automatic reportFail(input string msg);
        errorCount++;
        if (errorCount <= MAX_SHOWN) begin
            $display("FAIL %0t: %s", $time, msg);
        end else if (errorCount == MAX_SHOWN + 1) begin
            $display("further failures are counted but not printed");
        end
    endtask

    task automatic compareOutputs(input expectT want);
        checkCount++;
        assert ({mixedDe, mixedHs, mixedVs} === {want.de, want.hs, want.vs}) else
            reportFail($sformatf("de/hs/vs %b%b%b, expected %b%b%b", mixedDe, mixedHs,
                                 mixedVs, want.de, want.hs, want.vs));
        if (want.rgbValid) begin
            assert (mixedRgb === want.rgb) else
                reportFail($sformatf("pixel %h, expected %h", mixedRgb, want.rgb));
        end
    endtask

    // raster generator that checks outputs before each new drive
    task automatic runVideo();
        expectT want;
        int     l;
        forever begin
            for (int line = 0; line < ACTIVE_H + VBLANK; line++) begin
                for (int pos = 0; pos < LINE_CYCLES; pos++) begin
                    if (expectQ.size() == PIPE_DELAY) begin
                        compareOutputs(expectQ.pop_front());
                    end else begin
                        checkCount++;
                        assert ({mixedDe, mixedHs, mixedVs} === 3'b000) else
                            reportFail("syncs not low right after reset");
                    end
                    de  = (line >= VBLANK) && (pos < ACTIVE_W);
                    hs  = (pos >= ACTIVE_W + 8) && (pos < ACTIVE_W + 16);
                    vs  = (line == 1) || (line == 2);
                    rgb = PIX_BITS'($urandom());
                    if (line == 1 && pos == 0) begin
                        frameWin   = modelEnable && (vsCount > 0);
                        frameDirty = hostBusy;
                        vsCount++;
                    end
                    if (hostBusy) begin
                        frameDirty = 1'b1;
                    end
                    want = '{rgb: rgb, rgbValid: 1'b1, de: de, hs: hs, vs: vs};
                    l = line - VBLANK;
                    if (de && frameWin && l >= V_START && l < V_START + OSD_HEIGHT &&
                        pos >= H_START && pos < H_START + OSD_WIDTH) begin
                        want.rgb      = blendPixel(rgb, l - V_START, pos - H_START);
                        want.rgbValid = !frameDirty;
                    end
                    expectQ.push_back(want);
                    if (line == 1 && pos == 0) begin
                        -> frameStart;
                    end
                    @(posedge clk_video);
                    #1;
                end
            end
        end
    endtask

    // one word per strobe with rising edges 3 cycles apart
    task automatic sendWord(input logic [15:0] word);
        ioData   = word;
        ioStrobe = 1'b1;
        @(posedge clk_video);
        #1;
        ioStrobe = 1'b0;
        repeat (2) @(posedge clk_video);
        #1;
    endtask

    task automatic applyHostOp(input testRowT row);
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           dataByte;
        if (row.op != OP_IDLE) begin
            ioSelect = 1'b1;
            @(posedge clk_video);
            #1;
            if (row.op == OP_WRITE) begin
                hostBusy = 1'b1;
                sendWord({8'h00, 5'b00100, row.page});
                addr = {row.page, 8'h00};
                for (int i = 0; i < int'(row.count); i++) begin
                    dataByte = 8'($urandom());
                    sendWord({8'h00, dataByte});
                    bitmapModel[addr] = dataByte;
                    addr++;
                end
            end else begin
                sendWord({8'h00, 7'b0100000, row.enable});
            end
            ioSelect = 1'b0;
            // enable commits a few cycles after select drops
            repeat (4) @(posedge clk_video);
            #1;
            if (row.op == OP_ENABLE) begin
                modelEnable = row.enable;
            end
            hostBusy = 1'b0;
        end
    endtask

    initial begin : mainSeq
        int unsigned seedDummy;
        int          errorsBefore;
        hostOpE      opNow;
        reset       = 1'b1;
        ioSelect    = 1'b0;
        ioStrobe    = 1'b0;
        ioData      = '0;
        rgb         = '0;
        // syncs stay high until the raster starts
        de          = 1'b1;
        hs          = 1'b1;
        vs          = 1'b1;
        modelEnable = 1'b0;
        frameWin    = 1'b0;
        frameDirty  = 1'b0;
        hostBusy    = 1'b0;
        vsCount     = 0;
        errorCount  = 0;
        checkCount  = 0;
        seedDummy   = $urandom(SEED);
        repeat (4) @(posedge clk_video);
        #1;
        reset = 1'b0;
        fork
            runVideo();
        join_none
        for (int t = 0; t < NUM_TESTS; t++) begin
            errorsBefore = errorCount;
            opNow        = TEST_TABLE[t].op;
            @(frameStart);
            applyHostOp(TEST_TABLE[t]);
            repeat (TEST_TABLE[t].frames) @(frameStart);
            checkCount++;
            assert (osdStatus === TEST_TABLE[t].enable) else
                reportFail($sformatf("osdStatus %b, expected %b", osdStatus,
                                     TEST_TABLE[t].enable));
            $display("test %0d %s page %0d: %0d errors", t, opNow.name(),
                     TEST_TABLE[t].page, errorCount - errorsBefore);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        longint limitNs;
        limitNs = longint'(tableFrames() + 4) * FRAME_CYCLES * 10;
        #(limitNs);
        $display("TIMEOUT: the test table did not finish after %0t", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
osdPkg.sv
osdFetchIf.sv
osdControl.sv
osdBuffer.sv
osdGeometry.sv
osdMixer.sv
osdOverlay.sv
osdOverlay_properties.sv
tbOsdOverlay.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the OSD overlay

VERILATOR ?= verilator
TOP       ?= tbOsdOverlay
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_TEXT ?= Checks failed
PASS_TEXT ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation reported failures"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
